// File: all.f
logic/wordPkg.sv
logic/gamePkg.sv
logic/wordRegister.sv
logic/guessIntake.sv
logic/gameSequencer.sv
logic/wordGameTop.sv
verification/wordGame_properties.sv
verification/wordGameTb.sv

// File: logic/gamePkg.sv
//**************************************************************************
// game package
// sequencer states, host opcodes and round limits.
//**************************************************************************

package gamePkg;

    // the sixth miss loses the round.
    localparam int maxMistakes = 6;

    //**********************************************************************
    // sequencer states
    //**********************************************************************
    typedef enum logic [2:0] {
        SETUP = 3'd0, // waiting for a word and arm.
        SCAN  = 3'd1, // one position per cycle.
        JUDGE = 3'd2,
        READY = 3'd3, // waiting for a guess.
        OVER  = 3'd4  // round won or lost.
    } gameStateT;

    //**********************************************************************
    // host opcodes
    //**********************************************************************
    typedef enum logic [1:0] {
        LOADLETTER = 2'd0, // shift one letter in from the right.
        ARM        = 2'd1,
        ABORT      = 2'd2
    } hostOpT;

endpackage

// File: logic/gameSequencer.sv
//**************************************************************************
// game sequencer
// scans the secret word for each guess, keeps the revealed mask and the
// counts, and decides whether the round is won or lost.
//**************************************************************************

module gameSequencer (
    input  logic                                      clk,
    input  logic                                      nRst,
    input  wordPkg::letterT [wordPkg::wordLength-1:0] secretWord,
    input  logic                                      armPulse,
    input  logic                                      abortPulse,
    input  logic                                      guessStrobe,
    input  wordPkg::letterT                           guessLetter,
    output logic                                      judgeDone,
    output logic                                      ready,
    output logic                                      roundActive,
    output wordPkg::maskT                             revealed,
    output wordPkg::countT                            mistakes,
    output logic                                      won,
    output logic                                      lost
);
    import wordPkg::*;
    import gamePkg::*;

    typedef logic [$clog2(wordLength)-1:0] idxT;

    localparam idxT firstIdx = idxT'(wordLength - 1); // first letter slot.

    gameStateT state;
    gameStateT nextState;
    idxT       scanIdx;       // position under test.
    logic      newHit;        // this guess opened a position.
    countT     revealedCount;
    countT     mistakesNext;
    logic      posMatch;
    logic      wordDone;
    logic      outOfTries;

    // only unrevealed positions count as new.
    assign posMatch = (secretWord[scanIdx] == guessLetter) && !revealed[scanIdx];

    assign mistakesNext = newHit ? mistakes : mistakes + countT'(1);
    assign wordDone     = (revealedCount == countT'(wordLength));
    assign outOfTries   = (mistakesNext == countT'(maxMistakes));

    assign judgeDone   = (state == JUDGE);
    assign ready       = (state == READY);
    assign roundActive = (state == SCAN) || (state == JUDGE) || (state == READY);

    //**********************************************************************
    // next state
    //**********************************************************************
    always_comb begin
        nextState = state;
        case (state)
            SETUP, OVER: begin
                if (armPulse) begin
                    nextState = READY;
                end
            end
            READY: begin
                if (guessStrobe) begin
                    nextState = SCAN;
                end
            end
            SCAN: begin
                if (scanIdx == '0) begin
                    nextState = JUDGE; // last position done.
                end
            end
            JUDGE: begin
                if (wordDone || outOfTries) begin
                    nextState = OVER;
                end else begin
                    nextState = READY;
                end
            end
            default: begin
                nextState = SETUP;
            end
        endcase
        // abort wins from any state.
        if (abortPulse) begin
            nextState = SETUP;
        end
    end

    //**********************************************************************
    // state, mask and counts
    //**********************************************************************
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state         <= SETUP;
            scanIdx       <= '0;
            newHit        <= 1'b0;
            revealedCount <= '0;
            revealed      <= '0;
            mistakes      <= '0;
            won           <= 1'b0;
            lost          <= 1'b0;
        end else begin
            state <= nextState;
            case (state)
                SETUP, OVER: begin
                    if (nextState == READY) begin // fresh round.
                        revealedCount <= '0;
                        revealed      <= '0;
                        mistakes      <= '0;
                        won           <= 1'b0;
                        lost          <= 1'b0;
                    end
                end
                READY: begin
                    if (guessStrobe) begin
                        scanIdx <= firstIdx;
                        newHit  <= 1'b0;
                    end
                end
                SCAN: begin
                    if (posMatch) begin
                        revealed[scanIdx] <= 1'b1;
                        revealedCount     <= revealedCount + countT'(1);
                        newHit            <= 1'b1;
                    end
                    scanIdx <= scanIdx - idxT'(1);
                end
                JUDGE: begin
                    // a repeated letter opens nothing, so it is a miss.
                    mistakes <= mistakesNext;
                    won      <= wordDone;
                    lost     <= !wordDone && outOfTries;
                end
                default: begin
                    newHit <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: logic/guessIntake.sv
//**************************************************************************
// guess intake
// player side of the game. captures one guess, hands it to the sequencer
// and acknowledges it once judged.
//**************************************************************************

module guessIntake (
    input  logic            clk,
    input  logic            nRst,
    input  wordPkg::letterT guess,
    input  logic            guessReq,
    output logic            guessAck,
    input  logic            ready,
    input  logic            roundActive,
    output logic            guessStrobe,
    output wordPkg::letterT guessLetter,
    input  logic            judgeDone
);
    import wordPkg::*;

    logic pending;     // guess handed over, not yet judged.
    logic newReq;
    logic skipGuess;   // acked without judging.
    logic sendGuess;
    logic finishGuess;

    assign newReq    = guessReq && !guessAck && !pending;
    assign skipGuess = newReq && ((guess == noLetter) || !roundActive);
    assign sendGuess = newReq && !skipGuess && ready;

    // an abort mid-scan also releases the guess.
    assign finishGuess = pending && (judgeDone || !roundActive);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            pending     <= 1'b0;
            guessAck    <= 1'b0;
            guessStrobe <= 1'b0;
        end else begin
            guessStrobe <= sendGuess; // one cycle wide.
            if (sendGuess) begin
                pending <= 1'b1;
            end else if (finishGuess) begin
                pending <= 1'b0;
            end
            if (skipGuess || finishGuess) begin
                guessAck <= 1'b1;
            end else if (!guessReq) begin
                guessAck <= 1'b0;
            end
        end
    end

    // held stable while the sequencer scans.
    always_ff @(posedge clk) begin
        if (sendGuess) begin
            guessLetter <= guess;
        end
    end

endmodule

// File: logic/wordGameTop.sv
//**************************************************************************
// word game top
// connects the host word register, the player guess intake and the
// game sequencer.
//**************************************************************************

module wordGameTop (
    input  logic            clk,
    input  logic            nRst,
    input  gamePkg::hostOpT hostOp,
    input  wordPkg::letterT hostData,
    input  logic            hostReq,
    output logic            hostAck,
    input  wordPkg::letterT guess,
    input  logic            guessReq,
    output logic            guessAck,
    output wordPkg::maskT   revealed,
    output wordPkg::countT  mistakes,
    output logic            won,
    output logic            lost
);

    wordPkg::letterT [wordPkg::wordLength-1:0] secretWord;
    wordPkg::letterT                           guessLetter;
    logic                                      armPulse;
    logic                                      abortPulse;
    logic                                      guessStrobe;
    logic                                      judgeDone;
    logic                                      ready;
    logic                                      roundActive;

    // loads only outside a live round.
    wordRegister i_wordRegister (
        .clk          (clk),
        .nRst         (nRst),
        .hostOp       (hostOp),
        .hostData     (hostData),
        .hostReq      (hostReq),
        .hostAck      (hostAck),
        .canConfigure (~roundActive),
        .secretWord   (secretWord),
        .armPulse     (armPulse),
        .abortPulse   (abortPulse)
    );

    guessIntake i_guessIntake (
        .clk         (clk),
        .nRst        (nRst),
        .guess       (guess),
        .guessReq    (guessReq),
        .guessAck    (guessAck),
        .ready       (ready),
        .roundActive (roundActive),
        .guessStrobe (guessStrobe),
        .guessLetter (guessLetter),
        .judgeDone   (judgeDone)
    );

    gameSequencer i_gameSequencer (
        .clk         (clk),
        .nRst        (nRst),
        .secretWord  (secretWord),
        .armPulse    (armPulse),
        .abortPulse  (abortPulse),
        .guessStrobe (guessStrobe),
        .guessLetter (guessLetter),
        .judgeDone   (judgeDone),
        .ready       (ready),
        .roundActive (roundActive),
        .revealed    (revealed),
        .mistakes    (mistakes),
        .won         (won),
        .lost        (lost)
    );

endmodule

// File: logic/wordPkg.sv
//**************************************************************************
// word package
// letter, word and position mask types for the five-letter guessing game.
//**************************************************************************

package wordPkg;

    localparam int letterWidth = 8;
    localparam int wordLength  = 5; // fixed by the game rules.

    // opaque letter code.
    typedef logic [letterWidth-1:0] letterT;

    localparam letterT noLetter = '0; // code zero, no letter.

    // one bit per position, msb is the first letter.
    typedef logic [wordLength-1:0] maskT;

    // revealed letters and mistakes.
    typedef logic [2:0] countT;

endpackage

// File: logic/wordRegister.sv
//**************************************************************************
// word register
// host side of the game. runs the four-phase host handshake, shifts the
// secret word in one letter at a time and issues arm and abort pulses.
//**************************************************************************

module wordRegister (
    input  logic                                      clk,
    input  logic                                      nRst,
    input  gamePkg::hostOpT                           hostOp,
    input  wordPkg::letterT                           hostData,
    input  logic                                      hostReq,
    output logic                                      hostAck,
    input  logic                                      canConfigure,
    output wordPkg::letterT [wordPkg::wordLength-1:0] secretWord,
    output logic                                      armPulse,
    output logic                                      abortPulse
);
    import wordPkg::*;
    import gamePkg::*;

    logic takeCmd;    // fresh command this cycle.
    logic loadLetter;
    logic armCmd;
    logic abortCmd;

    // req up while ack is still low.
    assign takeCmd = hostReq && !hostAck;

    // opcode decode.
    assign loadLetter = takeCmd && (hostOp == LOADLETTER) && canConfigure;
    assign armCmd     = takeCmd && (hostOp == ARM);
    assign abortCmd   = takeCmd && (hostOp == ABORT);

    //**********************************************************************
    // handshake and command pulses
    //**********************************************************************
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            hostAck    <= 1'b0;
            armPulse   <= 1'b0;
            abortPulse <= 1'b0;
        end else begin
            armPulse   <= armCmd;   // same cycle as the ack.
            abortPulse <= abortCmd;
            if (takeCmd) begin
                hostAck <= 1'b1;
            end else if (!hostReq) begin
                hostAck <= 1'b0;    // req gone, close the handshake.
            end
        end
    end

    //**********************************************************************
    // secret word shift register
    //**********************************************************************
    // first letter loaded ends up in the top slot after five loads.
    always_ff @(posedge clk) begin
        if (loadLetter) begin
            secretWord <= {secretWord[wordLength-2:0], hostData};
        end
    end

endmodule

// File: verification/wordGameTb.sv
//**************************************************************************
// word game testbench
// runs host and player handshakes from a stimulus table and checks the
// revealed mask, mistakes, won and lost after every step.
//**************************************************************************

module wordGameTb;
    timeunit 1ns;
    timeprecision 1ps;

    import wordPkg::*;
    import gamePkg::*;

    localparam time clkPeriod = 40ns;
    localparam int  rowBudget = 40; // cycles per table row.

    typedef logic [letterWidth*wordLength-1:0] wordT;

    typedef enum {doLoadWord, doLoadLetter, doArm, doGuess, doAbort} actionT;

    typedef struct {
        actionT action;
        wordT   value;
        string  name;
        maskT   expRevealed;
        countT  expMistakes;
        logic   expWon;
        logic   expLost;
    } rowT;

    logic   clk = 1'b0;
    logic   nRst;
    hostOpT hostOp;
    letterT hostData;
    logic   hostReq;
    logic   hostAck;
    letterT guess;
    logic   guessReq;
    logic   guessAck;
    maskT   revealed;
    countT  mistakes;
    logic   won;
    logic   lost;

    rowT    rows[$];
    logic   tableReady = 1'b0;

    // reference model of the game.
    wordT   modelWord     = '0;
    maskT   modelRevealed = '0;
    countT  modelMistakes = '0;
    logic   modelWon      = 1'b0;
    logic   modelLost     = 1'b0;
    logic   modelLive     = 1'b0;

    wordGameTop i_wordGameTop (
        .clk      (clk),
        .nRst     (nRst),
        .hostOp   (hostOp),
        .hostData (hostData),
        .hostReq  (hostReq),
        .hostAck  (hostAck),
        .guess    (guess),
        .guessReq (guessReq),
        .guessAck (guessAck),
        .revealed (revealed),
        .mistakes (mistakes),
        .won      (won),
        .lost     (lost)
    );

    always #(clkPeriod / 2) clk = ~clk;

    //**********************************************************************
    // game rules
    //**********************************************************************
    task automatic applyRule(input actionT action, input wordT value);
        logic   hit;
        letterT letter;
        int     i;
        hit    = 1'b0;
        letter = value[letterWidth-1:0];
        case (action)
            doLoadWord: begin
                if (!modelLive) modelWord = value;
            end
            doLoadLetter: begin
                if (!modelLive) modelWord = {modelWord[letterWidth*(wordLength-1)-1:0], letter};
            end
            doArm: begin
                modelRevealed = '0;
                modelMistakes = '0;
                modelWon      = 1'b0;
                modelLost     = 1'b0;
                modelLive     = 1'b1;
            end
            doAbort: modelLive = 1'b0;
            doGuess: begin
                if (modelLive && letter != noLetter) begin
                    for (i = 0; i < wordLength; i++) begin
                        if (modelWord[i*letterWidth +: letterWidth] == letter
                                && !modelRevealed[i]) begin
                            modelRevealed[i] = 1'b1;
                            hit = 1'b1;
                        end
                    end
                    if (!hit) modelMistakes = modelMistakes + 1'b1; // repeats miss too.
                    if (modelRevealed == '1) begin
                        modelWon  = 1'b1;
                        modelLive = 1'b0;
                    end else if (modelMistakes == maxMistakes) begin
                        modelLost = 1'b1;
                        modelLive = 1'b0;
                    end
                end
            end
        endcase
    endtask

    // random letter that the current word does not hold.
    function automatic letterT absentLetter();
        letterT candidate;
        logic   clash;
        int     i;
        clash     = 1'b1;
        candidate = noLetter;
        while (clash) begin
            candidate = letterT'($urandom);
            clash = (candidate == noLetter);
            for (i = 0; i < wordLength; i++) begin
                if (modelWord[i*letterWidth +: letterWidth] == candidate) clash = 1'b1;
            end
        end
        return candidate;
    endfunction

    task automatic addRow(input actionT action, input wordT value, input string name);
        rowT row;
        applyRule(action, value);
        row.action      = action;
        row.value       = value;
        row.name        = name;
        row.expRevealed = modelRevealed;
        row.expMistakes = modelMistakes;
        row.expWon      = modelWon;
        row.expLost     = modelLost;
        rows.push_back(row);
    endtask

    //**********************************************************************
    // stimulus table
    //**********************************************************************
    task automatic buildTable();
        int n;
        addRow(doLoadWord, "LEVEL", "load LEVEL");
        addRow(doArm, '0, "arm LEVEL");
        addRow(doGuess, "E", "doubled E");
        addRow(doGuess, absentLetter(), "first miss");
        addRow(doGuess, "E", "repeated E");
        addRow(doGuess, '0, "zero guess");
        addRow(doLoadLetter, "Q", "load during round");
        addRow(doGuess, "L", "L after stray load");
        for (n = 3; n <= maxMistakes; n++) begin
            addRow(doGuess, absentLetter(), $sformatf("miss %0d", n));
        end
        addRow(doGuess, "V", "guess after loss");
        addRow(doAbort, '0, "abort after loss");
        addRow(doLoadWord, "CRANE", "load CRANE");
        addRow(doArm, '0, "arm CRANE");
        addRow(doGuess, "C", "guess C");
        addRow(doGuess, "R", "guess R");
        addRow(doGuess, absentLetter(), "CRANE miss");
        addRow(doGuess, "A", "guess A");
        addRow(doGuess, "N", "guess N");
        addRow(doGuess, "E", "guess E wins");
        addRow(doGuess, "Z", "guess after win");
        addRow(doLoadWord, "PLUMB", "load PLUMB");
        addRow(doArm, '0, "arm PLUMB");
        addRow(doGuess, "P", "guess P");
        addRow(doAbort, '0, "abort mid round");
        addRow(doGuess, "U", "guess after abort");
        addRow(doLoadWord, "TIGER", "load TIGER");
        addRow(doArm, '0, "arm TIGER");
        addRow(doGuess, "I", "guess I");
    endtask

    //**********************************************************************
    // handshake drivers
    //**********************************************************************
    task automatic hostCommand(input hostOpT op, input letterT data);
        @(posedge clk);
        hostOp   <= op;
        hostData <= data;
        hostReq  <= 1'b1;
        @(negedge clk);
        while (!hostAck) @(negedge clk);
        @(posedge clk);
        hostReq <= 1'b0;
        @(negedge clk);
        while (hostAck) @(negedge clk);
    endtask

    task automatic playerGuess(input letterT letter);
        @(posedge clk);
        guess    <= letter;
        guessReq <= 1'b1;
        @(negedge clk);
        while (!guessAck) @(negedge clk); // waits out a busy sequencer.
        @(posedge clk);
        guessReq <= 1'b0;
        @(negedge clk);
        while (guessAck) @(negedge clk);
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0d, actual %0d", testName, expected, actual);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic runRow(input rowT row);
        int i;
        case (row.action)
            doLoadWord: begin
                for (i = wordLength - 1; i >= 0; i--) begin
                    hostCommand(LOADLETTER, row.value[i*letterWidth +: letterWidth]);
                end
            end
            doLoadLetter: hostCommand(LOADLETTER, row.value[letterWidth-1:0]);
            doArm:        hostCommand(ARM, noLetter);
            doAbort:      hostCommand(ABORT, noLetter);
            doGuess:      playerGuess(row.value[letterWidth-1:0]);
        endcase
        checkValue({row.name, " revealed"}, row.expRevealed, revealed);
        checkValue({row.name, " mistakes"}, row.expMistakes, mistakes);
        checkValue({row.name, " won"}, row.expWon, won);
        checkValue({row.name, " lost"}, row.expLost, lost);
    endtask

    //**********************************************************************
    // main sequence and watchdog
    //**********************************************************************
    initial begin
        hostOp   = LOADLETTER;
        hostData = noLetter;
        hostReq  = 1'b0;
        guess    = noLetter;
        guessReq = 1'b0;
        nRst     = 1'b0;
        void'($urandom(6391));
        buildTable();
        tableReady = 1'b1;
        repeat (3) @(posedge clk);
        nRst <= 1'b1;
        @(negedge clk);
        checkValue("reset hostAck", 0, hostAck);
        checkValue("reset guessAck", 0, guessAck);
        checkValue("reset revealed", 0, revealed);
        checkValue("reset mistakes", 0, mistakes);
        checkValue("reset won", 0, won);
        checkValue("reset lost", 0, lost);
        foreach (rows[r]) begin
            runRow(rows[r]);
        end
        $display("All tests passed");
        $finish;
    end

    initial begin
        wait (tableReady);
        #((rows.size() + 2) * rowBudget * clkPeriod);
        $display("timeout: a handshake was never completed by the DUT");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: verification/wordGame_properties.sv
//**************************************************************************
// word game properties
// handshake and status rules checked on the game top level.
//**************************************************************************

module wordGameProperties (
    input logic           clk,
    input logic           nRst,
    input logic           hostReq,
    input logic           hostAck,
    input logic           guessReq,
    input logic           guessAck,
    input logic           roundActive,
    input wordPkg::maskT  revealed,
    input wordPkg::countT mistakes,
    input logic           won,
    input logic           lost
);
    timeunit 1ns;
    timeprecision 1ps;

    import gamePkg::*;

    // an ack only answers a live req.
    hostAckAfterReq: assert property (@(posedge clk) disable iff (!nRst)
        $rose(hostAck) |-> $past(hostReq))
        else $error("hostAck rose while hostReq was low");

    guessAckAfterReq: assert property (@(posedge clk) disable iff (!nRst)
        $rose(guessAck) |-> $past(guessReq))
        else $error("guessAck rose while guessReq was low");

    wonOrLost: assert property (@(posedge clk) disable iff (!nRst)
        !(won && lost))
        else $error("won and lost are high together");

    mistakeLimit: assert property (@(posedge clk) disable iff (!nRst)
        mistakes <= maxMistakes)
        else $error("mistakes went past the limit");

    // mask only grows while the round is live.
    revealedKept: assert property (@(posedge clk) disable iff (!nRst)
        $past(roundActive) |-> ((revealed & $past(revealed)) == $past(revealed)))
        else $error("a revealed position was cleared during a round");

endmodule

bind wordGameTop wordGameProperties i_wordGameProperties (
    .clk         (clk),
    .nRst        (nRst),
    .hostReq     (hostReq),
    .hostAck     (hostAck),
    .guessReq    (guessReq),
    .guessAck    (guessAck),
    .roundActive (roundActive),
    .revealed    (revealed),
    .mistakes    (mistakes),
    .won         (won),
    .lost        (lost)
);
